// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= pic_tb_top
FILELIST  ?= pic8259.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the grep, not from the simulator exit code
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/pic8259_top.sv ====
`timescale 1ns/100ps

module pic8259_top import pic_level_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr,
    input  logic      rd,
    input  logic      inta,
    input  logic      a0,
    input  pic_data_t din,
    input  pic_mask_t ir,
    output pic_data_t dout,
    output logic      dout_valid,
    output logic      intr
);

    pic_sched_if sched ();

    pic_control u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (wr),
        .rd         (rd),
        .inta       (inta),
        .a0         (a0),
        .din        (din),
        .dout       (dout),
        .dout_valid (dout_valid),
        .intr       (intr),
        .sched      (sched.ctrl)
    );

    pic_request_reg u_request_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .ir    (ir),
        .sched (sched.req)
    );

    pic_service_reg u_service_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .sched (sched.svc)
    );

    // ----------------------------------------
    // Resolvers, pending side and service side
    // ----------------------------------------
    pic_priority_resolver u_req_resolver (
        .candidates    (sched.irr & ~sched.imr),  // Masked lines never win
        .priority_base (sched.priority_base),
        .level         (sched.req_level),
        .valid         (sched.req_valid)
    );

    pic_priority_resolver u_svc_resolver (
        .candidates    (sched.isr),
        .priority_base (sched.priority_base),
        .level         (sched.svc_level),
        .valid         (sched.svc_valid)
    );

endmodule

// ==== logic/pic_cmd_pkg.sv ====
`include "pic_defs.svh"

// Programming words and register read choice
package pic_cmd_pkg;

    // Init sequencer steps
    typedef enum logic [1:0]
    {
        idle       = 2'd0,  // Waiting for ICW1
        await_icw2 = 2'd1,  // Vector base next
        await_icw4 = 2'd2,  // Mode word next
        ready      = 2'd3   // Operational, OCWs accepted
    } pic_init_state_t;

    // Source for a read at A0 = 0
    typedef enum logic
    {
        read_irr = 1'b0,
        read_isr = 1'b1
    } pic_read_sel_t;

    // OCW2 with the two marker bits stripped
    typedef struct packed
    {
        logic                    r;      // Rotate / set priority
        logic                    sl;     // Level field is meaningful
        logic                    eoi;    // End of interrupt
        logic [`PIC_LEVEL_W-1:0] level;  // L2..L0
    } pic_ocw2_t;

    // Upper vector bits from ICW2
    typedef logic [`VEC_BASE_W-1:0] pic_vec_base_t;

endpackage

// ==== logic/pic_control.sv ====
`timescale 1ns/100ps

module pic_control
    import pic_level_pkg::*;
    import pic_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr,
    input  logic      rd,
    input  logic      inta,
    input  logic      a0,
    input  pic_data_t din,
    output pic_data_t dout,
    output logic      dout_valid,
    output logic      intr,
    pic_sched_if.ctrl sched
);

    pic_init_state_t init_state;
    logic            need_icw4;     // IC4 seen in ICW1
    pic_vec_base_t   vec_base;
    pic_read_sel_t   read_sel;
    pic_ocw2_t       ocw2;
    logic            icw1_wr;
    logic            high_wr;       // Any write at A0 = 1
    logic            ocw2_wr;
    logic            ocw3_wr;
    logic            set_prio;
    pic_level_t      start;         // Highest priority level
    pic_level_t      req_rank;
    pic_level_t      svc_rank;
    logic            req_wins;
    pic_data_t       vector;
    pic_data_t       read_data;

    // ----------------------------------------
    // Write decode
    // ----------------------------------------
    assign icw1_wr = wr && !a0 && din[`ICW1_INIT_BIT];
    assign high_wr = wr && a0;
    // OCWs at A0 = 0 only once init is done
    assign ocw2_wr = wr && !a0 && !din[`ICW1_INIT_BIT] && !din[`OCW3_SEL_BIT]
                     && (init_state == ready);
    assign ocw3_wr = wr && !a0 && !din[`ICW1_INIT_BIT] && din[`OCW3_SEL_BIT]
                     && (init_state == ready);

    // Drop D4..D3 markers
    assign ocw2 = pic_ocw2_t'({din[`PIC_DATA_W-1 -: 3], din[`PIC_LEVEL_W-1:0]});

    assign set_prio = ocw2_wr && ocw2.r && ocw2.sl && !ocw2.eoi;

    // Specific names the level, non-specific ends the top one in service
    assign sched.eoi       = ocw2_wr && ocw2.eoi && (ocw2.sl || sched.svc_valid);
    assign sched.eoi_level = ocw2.sl ? ocw2.level : sched.svc_level;

    // Acknowledge only moves state when something is pending
    assign sched.ack       = inta && sched.req_valid;
    assign sched.ack_level = sched.req_level;

    // ----------------------------------------
    // Nesting check
    // ----------------------------------------
    assign start    = sched.priority_base + 1'b1;  // Wraps 7 -> 0
    assign req_rank = sched.req_level - start;     // 0 is highest priority
    assign svc_rank = sched.svc_level - start;
    assign req_wins = sched.req_valid && (!sched.svc_valid || (req_rank < svc_rank));

    // Idle inta returns level 7
    assign vector = {vec_base,
                     sched.req_valid ? sched.req_level : pic_level_t'(`PIC_LEVELS - 1)};

    assign read_data = a0                     ? sched.imr :
                       (read_sel == read_isr) ? sched.isr : sched.irr;

    // Init sequencer and operation registers
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            init_state          <= idle;
            need_icw4           <= 1'b0;
            sched.aeoi          <= 1'b0;
            sched.imr           <= '0;
            sched.priority_base <= pic_level_t'(`PIC_LEVELS - 1);
            read_sel            <= read_irr;
        end
        else
        begin
            if (icw1_wr)  // Restart from any state
            begin
                init_state          <= await_icw2;
                need_icw4           <= din[`ICW1_IC4_BIT];
                sched.aeoi          <= 1'b0;
                sched.imr           <= '0;
                sched.priority_base <= pic_level_t'(`PIC_LEVELS - 1);
                read_sel            <= read_irr;
            end
            else if (high_wr)
            begin
                case (init_state)
                    await_icw2: init_state <= need_icw4 ? await_icw4 : ready;
                    await_icw4:
                    begin
                        sched.aeoi <= din[`ICW4_AEOI_BIT];  // Rest of ICW4 ignored
                        init_state <= ready;
                    end
                    ready:      sched.imr <= din;  // OCW1
                    default:    ;                  // Stray write before ICW1
                endcase
            end

            if (set_prio)
                sched.priority_base <= ocw2.level;

            if (ocw3_wr && din[1])  // RR set, RIS picks ISR
                read_sel <= din[0] ? read_isr : read_irr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (high_wr && (init_state == await_icw2))
            vec_base <= din[`PIC_DATA_W-1 -: `VEC_BASE_W];  // ICW2 upper bits
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            intr       <= 1'b0;
            dout       <= '0;
            dout_valid <= 1'b0;
        end
        else
        begin
            intr       <= (init_state == ready) && req_wins;
            dout_valid <= rd || inta;
            if (inta)
                dout <= vector;     // inta beats rd
            else if (rd)
                dout <= read_data;
        end
    end

endmodule

// ==== logic/pic_defs.svh ====
`ifndef PIC_DEFS_SVH
`define PIC_DEFS_SVH

// Bus and level sizing
`define PIC_DATA_W      8   // Data bus width
`define PIC_LEVELS      8   // IR lines / priority levels
`define PIC_LEVEL_W     3   // Bits in a level number

// ----------------------------------------
// Command word bit positions
// ----------------------------------------
`define ICW1_INIT_BIT   4   // Set only in ICW1
`define ICW1_IC4_BIT    0   // ICW4 follows
`define ICW4_AEOI_BIT   1   // Auto end of interrupt
`define OCW3_SEL_BIT    3   // Tells OCW3 from OCW2

// Upper ICW2 bits kept, level fills the rest of the vector
`define VEC_BASE_W      5

`endif

// ==== logic/pic_level_pkg.sv ====
`include "pic_defs.svh"

// Types shared by everything that handles interrupt levels
package pic_level_pkg;

    // Encoded level, 0 to 7
    typedef logic [`PIC_LEVEL_W-1:0] pic_level_t;

    // One bit per IR line, bit n is level n
    typedef logic [`PIC_LEVELS-1:0] pic_mask_t;

    // Byte on the CPU side bus
    typedef logic [`PIC_DATA_W-1:0] pic_data_t;

endpackage

// ==== logic/pic_priority_resolver.sv ====
`timescale 1ns/100ps

// Picks the highest-priority set bit, priority_base + 1 first
module pic_priority_resolver import pic_level_pkg::*;
(
    input  pic_mask_t  candidates,
    input  pic_level_t priority_base,
    output pic_level_t level,
    output logic       valid
);

    logic [2*`PIC_LEVELS-1:0] doubled;
    pic_mask_t                rotated;  // Bit 0 is the top level
    pic_level_t               start;
    pic_level_t               offset;

    assign start = priority_base + 1'b1;

    // Shift a doubled copy so the wrap comes for free
    assign doubled = {candidates, candidates} >> start;
    assign rotated = doubled[`PIC_LEVELS-1:0];

    // Lowest set bit of the rotated mask
    always_comb
    begin
        offset = '0;
        for (int i = `PIC_LEVELS - 1; i >= 0; i--)
        begin
            if (rotated[i])
                offset = pic_level_t'(i);
        end
    end

    assign level = start + offset;  // Undo the rotation, mod 8
    assign valid = |candidates;

endmodule

// ==== logic/pic_request_reg.sv ====
`timescale 1ns/100ps

module pic_request_reg import pic_level_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  pic_mask_t ir,
    pic_sched_if.req sched
);

    pic_mask_t ir_q;      // First sample of the lines
    pic_mask_t ir_prev;   // Previous sample
    pic_mask_t rise;
    pic_mask_t ack_clr;

    assign rise = ir_q & ~ir_prev;  // Low to high only

    // Acknowledged level leaves IRR
    assign ack_clr = sched.ack ? (pic_mask_t'(1) << sched.ack_level) : '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ir_q      <= '0;
            ir_prev   <= '0;
            sched.irr <= '0;
        end
        else
        begin
            ir_q      <= ir;
            ir_prev   <= ir_q;
            sched.irr <= (sched.irr & ~ack_clr) | rise;  // New edge wins
        end
    end

endmodule

// ==== logic/pic_sched_if.sv ====
`timescale 1ns/100ps

// Register state and strobes between control and the datapath
interface pic_sched_if import pic_level_pkg::*; ();

    pic_mask_t  irr;            // Pending requests
    pic_mask_t  isr;            // Levels in service
    pic_mask_t  imr;            // Mask, 1 blocks the level
    pic_level_t priority_base;  // Lowest priority level
    pic_level_t req_level;      // Winning unmasked request
    logic       req_valid;
    pic_level_t svc_level;      // Highest level in service
    logic       svc_valid;
    logic       ack;            // One cycle, from inta
    pic_level_t ack_level;
    logic       aeoi;           // Auto-EOI mode
    logic       eoi;            // One cycle, from OCW2
    pic_level_t eoi_level;

    modport ctrl (
        output imr, priority_base, ack, ack_level, aeoi, eoi, eoi_level,
        input  irr, isr, req_level, req_valid, svc_level, svc_valid
    );

    modport req (output irr, input ack, ack_level);

    modport svc (output isr, input ack, ack_level, aeoi, eoi, eoi_level);

    // Resolver side, wired up at the top level
    modport sel (
        output req_level, req_valid, svc_level, svc_valid,
        input  irr, isr, imr, priority_base
    );

endinterface

// ==== logic/pic_service_reg.sv ====
`timescale 1ns/100ps

module pic_service_reg import pic_level_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    pic_sched_if.svc sched
);

    pic_mask_t set_mask;
    pic_mask_t clr_mask;

    // Auto-EOI skips the ISR entirely
    assign set_mask = (sched.ack && !sched.aeoi) ? (pic_mask_t'(1) << sched.ack_level)
                                                  : '0;
    assign clr_mask = sched.eoi ? (pic_mask_t'(1) << sched.eoi_level) : '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            sched.isr <= '0;
        else
            sched.isr <= (sched.isr & ~clr_mask) | set_mask;
    end

endmodule

// ==== pic8259.f ====
+incdir+logic
logic/pic_level_pkg.sv
logic/pic_cmd_pkg.sv
logic/pic_sched_if.sv
logic/pic_request_reg.sv
logic/pic_priority_resolver.sv
logic/pic_service_reg.sv
logic/pic_control.sv
logic/pic8259_top.sv
verif/pic_tb_clk.sv
verif/pic_tb_top.sv

// ==== verif/pic_tb_clk.sv ====
`timescale 1ns/100ps

// Free running testbench clock
module pic_tb_clk
#(
    parameter real period_ns = 4.0
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;  // 50 % duty
    end

endmodule

// ==== verif/pic_tb_top.sv ====
`timescale 1ns/100ps
`include "pic_defs.svh"

module pic_tb_top
    import pic_level_pkg::*;
    import pic_cmd_pkg::*;
();

    localparam int num_ops   = 240;  // Upper bound on bus operations
    localparam int op_cycles = 20;
    localparam int period_ns = 4;

    logic      clk;
    logic      rst_n;
    logic      wr;
    logic      rd;
    logic      inta;
    logic      a0;
    pic_data_t din;
    pic_mask_t ir;
    pic_data_t dout;
    logic      dout_valid;
    logic      intr;
    integer    seed = 96327;

    // Reference model state
    pic_mask_t     m_irr;
    pic_mask_t     m_isr;
    pic_mask_t     m_imr;
    pic_level_t    m_base;     // Lowest priority level
    pic_vec_base_t m_vbase;
    logic          m_aeoi;
    logic          m_ready;    // Init sequence done
    pic_read_sel_t m_rsel;

    pic_tb_clk #(.period_ns(period_ns)) u_clk (.clk(clk));

    pic8259_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (wr),
        .rd         (rd),
        .inta       (inta),
        .a0         (a0),
        .din        (din),
        .ir         (ir),
        .dout       (dout),
        .dout_valid (dout_valid),
        .intr       (intr)
    );

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input pic_data_t expected,
                              input pic_data_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] t=%0t %s expected 8'h%02h actual 8'h%02h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // High may show early, low is judged when the window closes
    task automatic check_intr(input logic expected);
        int waited;
        waited = 0;
        while (waited < 6 && !(expected && intr))
        begin
            @(negedge clk);
            waited++;
        end
        if (intr !== expected)
        begin
            $display("[FAIL] t=%0t intr expected %0b actual %0b", $time, expected, intr);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic pic_level_t level_at_rank(input int rank);
        return pic_level_t'(m_base + 1 + rank);  // Rank 0 is base + 1
    endfunction

    function automatic pic_level_t rank_of(input pic_level_t lvl);
        return pic_level_t'(lvl - m_base - 1);
    endfunction

    // Highest priority set bit, level 7 when mask is empty
    function automatic logic model_pick(input pic_mask_t mask, output pic_level_t lvl);
        logic found;
        found = 1'b0;
        lvl   = pic_level_t'(7);
        for (int k = `PIC_LEVELS - 1; k >= 0; k--)
        begin
            if (mask[level_at_rank(k)])
            begin
                found = 1'b1;
                lvl   = level_at_rank(k);
            end
        end
        return found;
    endfunction

    function automatic logic model_intr();
        pic_level_t req_lvl;
        pic_level_t svc_lvl;
        logic       req_v;
        logic       svc_v;
        req_v = model_pick(m_irr & ~m_imr, req_lvl);
        svc_v = model_pick(m_isr, svc_lvl);
        return m_ready && req_v && (!svc_v || rank_of(req_lvl) < rank_of(svc_lvl));
    endfunction

    // ----------------------------------------
    // Bus operations, driven on falling edges
    // ----------------------------------------
    task automatic bus_write(input logic addr, input pic_data_t data);
        @(negedge clk);
        wr  = 1'b1;
        a0  = addr;
        din = data;
        @(negedge clk);
        wr  = 1'b0;
    endtask

    task automatic collect_dout(output pic_data_t data);
        int waited;
        waited = 0;
        while (!dout_valid && waited < 4)
        begin
            @(negedge clk);
            waited++;
        end
        if (!dout_valid)
        begin
            $display("No dout_valid within 4 cycles of a read or acknowledge at t=%0t", $time);
            abort_run();
        end
        else
        begin
            data = dout;
            @(negedge clk);         // Valid lasts one cycle only
            if (dout_valid !== 1'b0)
            begin
                $display("[FAIL] t=%0t dout_valid expected 0 actual %0b", $time, dout_valid);
                abort_run();
            end
        end
    endtask

    task automatic read_check(input logic addr);
        pic_data_t got;
        string     name;
        @(negedge clk);
        rd = 1'b1;
        a0 = addr;
        @(negedge clk);
        rd = 1'b0;
        collect_dout(got);
        name = addr ? "imr" : ((m_rsel == read_isr) ? "isr" : "irr");
        check_byte(name, addr ? m_imr : ((m_rsel == read_isr) ? m_isr : m_irr), got);
    endtask

    task automatic acknowledge();
        pic_data_t  got;
        pic_level_t lvl;
        logic       valid;
        valid = model_pick(m_irr & ~m_imr, lvl);
        @(negedge clk);
        inta = 1'b1;
        @(negedge clk);
        inta = 1'b0;
        collect_dout(got);
        check_byte("dout", {m_vbase, lvl}, got);
        if (valid)
        begin
            m_irr[lvl] = 1'b0;
            if (!m_aeoi)
                m_isr[lvl] = 1'b1;
        end
    endtask

    // One cycle high pulse, irr picks it up two edges later
    task automatic pulse_lines(input pic_mask_t lines);
        @(negedge clk);
        ir = lines;
        @(negedge clk);
        ir = '0;
        @(negedge clk);
        m_irr |= lines;
    endtask

    task automatic send_ocw2(input logic r, input logic sl, input logic eoi,
                             input pic_level_t lvl);
        pic_level_t top;
        bus_write(1'b0, {r, sl, eoi, 2'b00, lvl});
        if (eoi && sl)
            m_isr[lvl] = 1'b0;           // Specific
        else if (eoi && model_pick(m_isr, top))
            m_isr[top] = 1'b0;           // Non-specific
        else if (r && sl && !eoi)
            m_base = lvl;
    endtask

    task automatic select_read(input pic_read_sel_t sel);
        bus_write(1'b0, {6'b000010, 1'b1, sel == read_isr});  // OCW3 with RR set
        m_rsel = sel;
    endtask

    task automatic write_mask(input pic_mask_t mask);
        bus_write(1'b1, mask);
        m_imr = mask;
    endtask

    task automatic init_pic(input pic_vec_base_t vbase, input logic use_icw4,
                            input logic aeoi);
        bus_write(1'b0, {7'b0001000, use_icw4});
        m_ready = 1'b0;             // ICW1 restarts the sequence
        m_imr   = '0;
        m_base  = pic_level_t'(7);
        m_rsel  = read_irr;
        check_intr(model_intr());   // Held low until ready
        bus_write(1'b1, {vbase, 3'b000});
        if (use_icw4)
            bus_write(1'b1, {6'b000000, aeoi, 1'b1});
        m_vbase = vbase;
        m_aeoi  = use_icw4 && aeoi;
        m_ready = 1'b1;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial
    begin
        pic_level_t lvl, a, lo, hi;
        int         rank_a;
        rst_n = 1'b0;
        {wr, rd, inta, a0} = 4'b0000;
        din   = '0;
        ir    = '0;
        {m_irr, m_isr, m_imr} = '0;
        m_base  = pic_level_t'(7);
        m_vbase = '0;
        m_aeoi  = 1'b0;
        m_ready = 1'b0;
        m_rsel  = read_irr;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Single requests, acknowledge, specific EOI
        init_pic(pic_vec_base_t'($random(seed)), 1'b0, 1'b0);
        repeat (8)
        begin
            lvl = pic_level_t'($random(seed));
            pulse_lines(pic_mask_t'(1) << lvl);
            check_intr(model_intr());
            acknowledge();
            send_ocw2(1'b0, 1'b1, 1'b1, lvl);
            check_intr(model_intr());
        end

        // Masking, then drain with the mask open
        write_mask(pic_mask_t'($random(seed)));
        read_check(1'b1);
        pulse_lines('1);
        check_intr(model_intr());
        read_check(1'b0);
        acknowledge();
        send_ocw2(1'b0, 1'b0, 1'b1, '0);
        write_mask('1);
        check_intr(model_intr());       // Full mask blocks every request
        write_mask('0);
        while (m_irr != '0)
        begin
            check_intr(model_intr());
            acknowledge();
            send_ocw2(1'b0, 1'b0, 1'b1, '0);
        end

        // Nesting around one level in service
        rank_a = 1 + ($unsigned($random(seed)) % 6);
        a  = level_at_rank(rank_a);
        lo = level_at_rank(rank_a + 1 + ($unsigned($random(seed)) % (7 - rank_a)));
        hi = level_at_rank($unsigned($random(seed)) % rank_a);
        pulse_lines(pic_mask_t'(1) << a);
        acknowledge();
        pulse_lines(pic_mask_t'(1) << lo);
        check_intr(model_intr());       // Blocked by a
        pulse_lines(pic_mask_t'(1) << hi);
        check_intr(model_intr());       // Outranks a
        acknowledge();
        select_read(read_isr);
        read_check(1'b0);
        repeat (2)
        begin
            send_ocw2(1'b0, 1'b0, 1'b1, '0);
            read_check(1'b0);
        end
        acknowledge();
        send_ocw2(1'b0, 1'b0, 1'b1, '0);
        read_check(1'b0);

        // Set priority, rotated service order
        send_ocw2(1'b1, 1'b1, 1'b0, pic_level_t'($unsigned($random(seed)) % 7));  // Never 7
        pulse_lines('1);
        repeat (`PIC_LEVELS)
        begin
            check_intr(model_intr());
            acknowledge();
            send_ocw2(1'b0, 1'b0, 1'b1, '0);
        end

        // Status reads between random rises
        repeat (4)
        begin
            pulse_lines(pic_mask_t'($random(seed)));
            select_read(read_irr);
            read_check(1'b0);
            acknowledge();
            select_read(read_isr);
            read_check(1'b0);
        end
        while (m_isr != '0 || m_irr != '0)
        begin
            if (m_irr != '0)
                acknowledge();
            send_ocw2(1'b0, 1'b0, 1'b1, '0);
        end
        acknowledge();                  // Nothing pending, level 7
        read_check(1'b0);

        // Auto-EOI, ISR never fills
        pulse_lines(pic_mask_t'($random(seed)) | pic_mask_t'(1));
        init_pic(pic_vec_base_t'($random(seed)), 1'b1, 1'b1);
        while (m_irr != '0)
        begin
            check_intr(model_intr());
            acknowledge();
        end
        check_intr(model_intr());
        select_read(read_isr);
        read_check(1'b0);

        $display("Simulation finished: PASS");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(num_ops * op_cycles * period_ns);
        $display("Watchdog expired after %0d cycles before the tests completed",
                 num_ops * op_cycles);
        abort_run();
    end

endmodule
